// ==== pw_pkg.sv ====
`default_nettype none

package pw_pkg;

   ////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////

   localparam int PATTERN_BYTES = 8;
   localparam int BYTE_IDX_W    = 3;   // index into the pattern bytes
   localparam int PCOUNT_W      = 4;   // 0..8 compared bytes
   localparam int TRIG_DELAY_W  = 16;
   localparam int TRIG_WIDTH_W  = 8;
   localparam int CAP_LEN_W     = 8;
   localparam int DELTA_W       = 8;   // short timestamp, saturates
   localparam int STAT_W        = 4;   // rxactive, rxerror, linestate[1:0]
   localparam int TRIG_ST_W     = 2;

   ////////////////////////////////////////////////////////////
   // register map, one byte per address
   ////////////////////////////////////////////////////////////

   localparam logic [7:0] REG_PATTERN_BASE  = 8'h00;  // 0x00..0x07
   localparam logic [7:0] REG_MASK_BASE     = 8'h08;  // 0x08..0x0f
   localparam logic [7:0] REG_PATTERN_COUNT = 8'h10;
   localparam logic [7:0] REG_TRIG_DELAY_LO = 8'h11;
   localparam logic [7:0] REG_TRIG_DELAY_HI = 8'h12;
   localparam logic [7:0] REG_TRIG_WIDTH    = 8'h13;
   localparam logic [7:0] REG_CAP_LEN       = 8'h14;
   localparam logic [7:0] REG_SPEED         = 8'h15;
   localparam logic [7:0] REG_ARM           = 8'h16;

   // link speed codes
   localparam logic [1:0] SPEED_FS   = 2'd0;
   localparam logic [1:0] SPEED_LS   = 2'd1;
   localparam logic [1:0] SPEED_HS   = 2'd2;
   localparam logic [1:0] SPEED_AUTO = 2'd3;  // no autodetect here, runs as fs

   // capture record commands
   localparam logic [1:0] CMD_DATA = 2'd0;
   localparam logic [1:0] CMD_STAT = 2'd1;

   // trigger generator states
   localparam logic [TRIG_ST_W-1:0] TRIG_ST_IDLE  = 2'd0;
   localparam logic [TRIG_ST_W-1:0] TRIG_ST_DELAY = 2'd1;
   localparam logic [TRIG_ST_W-1:0] TRIG_ST_PULSE = 2'd2;

   ////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [PATTERN_BYTES-1:0][7:0] pattern;
      logic [PATTERN_BYTES-1:0][7:0] mask;     // 1 = bit is compared
      logic [PCOUNT_W-1:0]           pattern_count;
      logic [TRIG_DELAY_W-1:0]       trig_delay;
      logic [TRIG_WIDTH_W-1:0]       trig_width;
      logic [CAP_LEN_W-1:0]          cap_len;
   } pw_cfg_t;

   typedef struct packed {
      logic                  data_valid;
      logic [7:0]            data;
      logic                  first;       // byte 0 of a packet
      logic [BYTE_IDX_W-1:0] byte_idx;    // sticks at the top value
      logic                  stat_valid;
      logic [STAT_W-1:0]     status;
      logic [DELTA_W-1:0]    delta;
   } rx_event_t;

   typedef struct packed {
      logic [1:0]         cmd;
      logic [DELTA_W-1:0] delta;
      logic [7:0]         data;
   } cap_data_t;

   typedef struct packed {
      logic [1:0]         cmd;
      logic [DELTA_W-1:0] delta;
      logic [3:0]         rsvd;   // always zero
      logic [STAT_W-1:0]  status;
   } cap_stat_t;

   // 18-bit capture word, cmd tells which view applies
   typedef union packed {
      cap_data_t data;
      cap_stat_t stat;
   } cap_record_u;

endpackage

`default_nettype wire

// ==== pw_regs.sv ====
`default_nettype none

module pw_regs (
   input  wire              fe_clk_i,
   input  wire              arst_n_i,
   input  wire              reg_write_i,
   input  wire [7:0]        reg_addr_i,
   input  wire [7:0]        reg_data_i,
   input  wire              cap_done_i,
   output pw_pkg::pw_cfg_t  cfg_o,
   output logic             armed_o,
   output logic [1:0]       xcvrsel_o,
   output logic             termsel_o
);

   logic [1:0]                    speed_q;
   logic [pw_pkg::BYTE_IDX_W-1:0] sel;

   assign sel = reg_addr_i[pw_pkg::BYTE_IDX_W-1:0];  // byte within pattern/mask

   ////////////////////////////////////////////////////////////
   // write decode
   ////////////////////////////////////////////////////////////

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_o   <= '0;
         speed_q <= pw_pkg::SPEED_FS;
         armed_o <= 1'b0;
      end else begin
         if (cap_done_i) armed_o <= 1'b0;  // capture finished
         if (reg_write_i) begin
            if (reg_addr_i[7:3] == pw_pkg::REG_PATTERN_BASE[7:3]) begin
               cfg_o.pattern[sel] <= reg_data_i;
            end else if (reg_addr_i[7:3] == pw_pkg::REG_MASK_BASE[7:3]) begin
               cfg_o.mask[sel] <= reg_data_i;
            end else begin
               case (reg_addr_i)
                  pw_pkg::REG_PATTERN_COUNT:
                     cfg_o.pattern_count <= reg_data_i[pw_pkg::PCOUNT_W-1:0];
                  pw_pkg::REG_TRIG_DELAY_LO: cfg_o.trig_delay[7:0]  <= reg_data_i;
                  pw_pkg::REG_TRIG_DELAY_HI: cfg_o.trig_delay[15:8] <= reg_data_i;
                  pw_pkg::REG_TRIG_WIDTH:    cfg_o.trig_width       <= reg_data_i;
                  pw_pkg::REG_CAP_LEN:       cfg_o.cap_len          <= reg_data_i;
                  pw_pkg::REG_SPEED:         speed_q                <= reg_data_i[1:0];
                  pw_pkg::REG_ARM: begin
                     // a re-arm in the same cycle as done wins
                     if (reg_data_i[0]) armed_o <= 1'b1;
                  end
                  default: ;
               endcase
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // transceiver select from the speed code
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (speed_q)
         pw_pkg::SPEED_LS: begin
            xcvrsel_o = 2'b10;
            termsel_o = 1'b1;
         end
         pw_pkg::SPEED_HS: begin
            xcvrsel_o = 2'b00;
            termsel_o = 1'b0;
         end
         pw_pkg::SPEED_FS, pw_pkg::SPEED_AUTO: begin
            xcvrsel_o = 2'b01;
            termsel_o = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== fe_rx_front.sv ====
`default_nettype none

module fe_rx_front (
   input  wire                fe_clk_i,
   input  wire                arst_n_i,
   input  wire [7:0]          fe_data_i,
   input  wire                fe_rxvalid_i,
   input  wire                fe_rxactive_i,
   input  wire                fe_rxerror_i,
   input  wire [1:0]          fe_linestate_i,
   input  wire                armed_i,
   output pw_pkg::rx_event_t  event_o
);

   logic [pw_pkg::STAT_W-1:0]     stat_now;
   logic [pw_pkg::STAT_W-1:0]     stat_q;    // last cycle's pin status
   logic [pw_pkg::BYTE_IDX_W-1:0] idx_q;
   logic [pw_pkg::BYTE_IDX_W-1:0] idx_now;
   logic [pw_pkg::DELTA_W-1:0]    delta_q;
   logic                          armed_q;
   logic                          pkt_start;
   logic                          stat_chg;
   logic                          any_evt;
   logic                          arm_rise;

   assign stat_now  = {fe_rxactive_i, fe_rxerror_i, fe_linestate_i};
   assign pkt_start = fe_rxactive_i & ~stat_q[pw_pkg::STAT_W-1];  // rxactive rising
   assign idx_now   = pkt_start ? '0 : idx_q;
   assign stat_chg  = (stat_now != stat_q);
   assign any_evt   = fe_rxvalid_i | stat_chg;
   assign arm_rise  = armed_i & ~armed_q;

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stat_q  <= '0;
         idx_q   <= '0;
         delta_q <= '0;
         armed_q <= 1'b0;
         event_o <= '0;
      end else begin
         stat_q  <= stat_now;
         armed_q <= armed_i;

         // byte position inside the packet, holds at the last index
         if (fe_rxvalid_i) begin
            idx_q <= (idx_now == '1) ? idx_now : idx_now + 1'b1;
         end else if (pkt_start) begin
            idx_q <= '0;
         end

         // cycles since last event
         if (any_evt) begin
            delta_q <= {{(pw_pkg::DELTA_W-1){1'b0}}, 1'b1};
         end else if (arm_rise) begin
            delta_q <= '0;
         end else if (delta_q != '1) begin
            delta_q <= delta_q + 1'b1;
         end

         event_o.data_valid <= fe_rxvalid_i;
         event_o.data       <= fe_data_i;
         event_o.first      <= fe_rxvalid_i & (idx_now == '0);
         event_o.byte_idx   <= idx_now;
         event_o.stat_valid <= stat_chg;
         event_o.status     <= stat_now;
         event_o.delta      <= delta_q;
      end
   end

endmodule

`default_nettype wire

// ==== pattern_match.sv ====
`default_nettype none

module pattern_match (
   input  wire                fe_clk_i,
   input  wire                arst_n_i,
   input  pw_pkg::pw_cfg_t    cfg_i,
   input  wire                armed_i,
   input  pw_pkg::rx_event_t  event_i,
   output logic               match_o
);

   logic [pw_pkg::PCOUNT_W-1:0] idx_ext;
   logic [7:0]                  pat_byte;
   logic [7:0]                  msk_byte;
   logic                        byte_ok;
   logic                        in_window;
   logic                        last_byte;
   logic                        still_now;
   logic                        still_q;   // packet matched so far
   logic                        fired_q;   // already matched this arm

   assign idx_ext  = {{(pw_pkg::PCOUNT_W-pw_pkg::BYTE_IDX_W){1'b0}}, event_i.byte_idx};
   assign pat_byte = cfg_i.pattern[event_i.byte_idx];
   assign msk_byte = cfg_i.mask[event_i.byte_idx];

   // only bits with mask set take part
   assign byte_ok   = ((event_i.data ^ pat_byte) & msk_byte) == 8'h00;
   assign in_window = idx_ext < cfg_i.pattern_count;
   assign last_byte = idx_ext == (cfg_i.pattern_count - 1'b1);
   assign still_now = (event_i.first | still_q) & byte_ok;  // byte 0 restarts

   ////////////////////////////////////////////////////////////
   // per packet match state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         still_q <= 1'b0;
         fired_q <= 1'b0;
         match_o <= 1'b0;
      end else begin
         match_o <= 1'b0;
         if (event_i.data_valid && in_window) begin
            still_q <= still_now;
         end

         if (!armed_i) begin
            fired_q <= 1'b0;  // ready again for the next arm
         end else if (event_i.data_valid && in_window && last_byte &&
                      still_now && !fired_q) begin
            match_o <= 1'b1;
            fired_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== trigger_gen.sv ====
`default_nettype none

module trigger_gen (
   input  wire              fe_clk_i,
   input  wire              arst_n_i,
   input  pw_pkg::pw_cfg_t  cfg_i,
   input  wire              match_i,
   output logic             trig_o
);

   logic [pw_pkg::TRIG_ST_W-1:0]    state_q;
   logic [pw_pkg::TRIG_DELAY_W-1:0] cnt_q;      // shared by delay and width
   logic [pw_pkg::TRIG_DELAY_W-1:0] width_ext;

   assign width_ext = {{(pw_pkg::TRIG_DELAY_W-pw_pkg::TRIG_WIDTH_W){1'b0}},
                       cfg_i.trig_width};

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= pw_pkg::TRIG_ST_IDLE;
         cnt_q   <= '0;
         trig_o  <= 1'b0;
      end else begin
         case (state_q)
            pw_pkg::TRIG_ST_IDLE: begin
               // zero width means no pulse at all
               if (match_i && cfg_i.trig_width != '0) begin
                  if (cfg_i.trig_delay == '0) begin
                     trig_o  <= 1'b1;
                     cnt_q   <= width_ext - 1'b1;
                     state_q <= pw_pkg::TRIG_ST_PULSE;
                  end else begin
                     cnt_q   <= cfg_i.trig_delay - 1'b1;
                     state_q <= pw_pkg::TRIG_ST_DELAY;
                  end
               end
            end
            pw_pkg::TRIG_ST_DELAY: begin
               if (cnt_q == '0) begin
                  trig_o  <= 1'b1;
                  cnt_q   <= width_ext - 1'b1;
                  state_q <= pw_pkg::TRIG_ST_PULSE;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            pw_pkg::TRIG_ST_PULSE: begin
               if (cnt_q == '0) begin
                  trig_o  <= 1'b0;
                  state_q <= pw_pkg::TRIG_ST_IDLE;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: state_q <= pw_pkg::TRIG_ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== capture_out.sv ====
`default_nettype none

module capture_out (
   input  wire                  fe_clk_i,
   input  wire                  arst_n_i,
   input  pw_pkg::pw_cfg_t      cfg_i,
   input  wire                  match_i,
   input  pw_pkg::rx_event_t    event_i,
   output logic                 capturing_o,
   output logic                 cap_valid_o,
   output pw_pkg::cap_record_u  cap_record_o,
   output logic                 cap_done_o
);

   logic [pw_pkg::CAP_LEN_W-1:0] cnt_q;     // records sent this capture
   logic [pw_pkg::CAP_LEN_W-1:0] cnt_base;
   logic [pw_pkg::CAP_LEN_W-1:0] cnt_next;
   pw_pkg::cap_record_u          rec_next;
   logic                         active;
   logic                         take_data;
   logic                         take_stat;
   logic                         emit;

   assign active    = capturing_o | match_i;  // event beside the match counts
   assign take_data = active & event_i.data_valid;
   // a status change together with a byte is carried by the data record
   assign take_stat = active & event_i.stat_valid & ~event_i.data_valid;
   assign emit      = take_data | take_stat;
   assign cnt_base  = match_i ? '0 : cnt_q;
   assign cnt_next  = cnt_base + 1'b1;

   ////////////////////////////////////////////////////////////
   // record build
   ////////////////////////////////////////////////////////////

   always_comb begin
      rec_next = '0;
      if (take_stat) begin
         rec_next.stat.cmd    = pw_pkg::CMD_STAT;
         rec_next.stat.delta  = event_i.delta;
         rec_next.stat.rsvd   = '0;
         rec_next.stat.status = event_i.status;
      end else begin
         rec_next.data.cmd   = pw_pkg::CMD_DATA;
         rec_next.data.delta = event_i.delta;
         rec_next.data.data  = event_i.data;
      end
   end

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         capturing_o <= 1'b0;
         cap_valid_o <= 1'b0;
         cap_done_o  <= 1'b0;
         cnt_q       <= '0;
      end else begin
         cap_valid_o <= emit;
         cap_done_o  <= 1'b0;
         if (match_i) capturing_o <= 1'b1;
         if (emit) begin
            cnt_q <= cnt_next;
            // cap_len of 0 wraps, giving 256 records
            if (cnt_next == cfg_i.cap_len) begin
               capturing_o <= 1'b0;
               cap_done_o  <= 1'b1;
            end
         end else if (match_i) begin
            cnt_q <= '0;
         end
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (emit) cap_record_o <= rec_next;
   end

endmodule

`default_nettype wire

// ==== pw_top.sv ====
`default_nettype none

module pw_top (
   input  wire                  fe_clk_i,
   input  wire                  arst_n_i,
   // register write port
   input  wire                  reg_write_i,
   input  wire [7:0]            reg_addr_i,
   input  wire [7:0]            reg_data_i,
   // utmi receive side
   input  wire [7:0]            fe_data_i,
   input  wire                  fe_rxvalid_i,
   input  wire                  fe_rxactive_i,
   input  wire                  fe_rxerror_i,
   input  wire [1:0]            fe_linestate_i,
   output wire [1:0]            xcvrsel_o,
   output wire                  termsel_o,
   output wire                  trig_o,
   output wire                  armed_o,
   output wire                  capturing_o,
   output wire                  cap_valid_o,
   output pw_pkg::cap_record_u  cap_record_o
);

   pw_pkg::pw_cfg_t    cfg;
   pw_pkg::rx_event_t  rx_evt;
   wire                match;
   wire                cap_done;

   pw_regs u_regs (
      .fe_clk_i    (fe_clk_i),
      .arst_n_i    (arst_n_i),
      .reg_write_i (reg_write_i),
      .reg_addr_i  (reg_addr_i),
      .reg_data_i  (reg_data_i),
      .cap_done_i  (cap_done),
      .cfg_o       (cfg),
      .armed_o     (armed_o),
      .xcvrsel_o   (xcvrsel_o),
      .termsel_o   (termsel_o)
   );

   fe_rx_front u_fe_rx_front (
      .fe_clk_i       (fe_clk_i),
      .arst_n_i       (arst_n_i),
      .fe_data_i      (fe_data_i),
      .fe_rxvalid_i   (fe_rxvalid_i),
      .fe_rxactive_i  (fe_rxactive_i),
      .fe_rxerror_i   (fe_rxerror_i),
      .fe_linestate_i (fe_linestate_i),
      .armed_i        (armed_o),
      .event_o        (rx_evt)
   );

   pattern_match u_pattern_match (
      .fe_clk_i (fe_clk_i),
      .arst_n_i (arst_n_i),
      .cfg_i    (cfg),
      .armed_i  (armed_o),
      .event_i  (rx_evt),
      .match_o  (match)
   );

   trigger_gen u_trigger_gen (
      .fe_clk_i (fe_clk_i),
      .arst_n_i (arst_n_i),
      .cfg_i    (cfg),
      .match_i  (match),
      .trig_o   (trig_o)
   );

   capture_out u_capture_out (
      .fe_clk_i     (fe_clk_i),
      .arst_n_i     (arst_n_i),
      .cfg_i        (cfg),
      .match_i      (match),
      .event_i      (rx_evt),
      .capturing_o  (capturing_o),
      .cap_valid_o  (cap_valid_o),
      .cap_record_o (cap_record_o),
      .cap_done_o   (cap_done)
   );

endmodule

`default_nettype wire

// ==== pw_sva.sv ====
`default_nettype none

module trig_sva (
   input wire              fe_clk_i,
   input wire              arst_n_i,
   input wire [1:0]        state_q,
   input wire              trig_o,
   input pw_pkg::pw_cfg_t  cfg_i,
   input wire              match_i
);

   logic [7:0] hi_cnt;      // cycles trig_o has been high
   logic       seen_match;  // a match arrived since reset

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hi_cnt     <= '0;
         seen_match <= 1'b0;
      end else begin
         hi_cnt <= trig_o ? hi_cnt + 8'd1 : 8'd0;
         if (match_i) seen_match <= 1'b1;
      end
   end

   // no pulse while still counting the delay
   assert property (@(posedge fe_clk_i) disable iff (!arst_n_i)
      (state_q == pw_pkg::TRIG_ST_DELAY) |-> !trig_o)
      else $error("trig_o high during delay count");

   assert property (@(posedge fe_clk_i) disable iff (!arst_n_i)
      $fell(trig_o) |-> (hi_cnt == cfg_i.trig_width))
      else $error("trigger pulse width differs from trig_width");

   assert property (@(posedge fe_clk_i) disable iff (!arst_n_i)
      !seen_match |-> !trig_o)
      else $error("trig_o high before any match");

endmodule

bind trigger_gen trig_sva u_trig_sva (
   .fe_clk_i (fe_clk_i),
   .arst_n_i (arst_n_i),
   .state_q  (state_q),
   .trig_o   (trig_o),
   .cfg_i    (cfg_i),
   .match_i  (match_i)
);

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker (
   input wire                  clk_i,
   input wire                  arst_n_i,
   input wire [31:0]           cyc_i,      // rising edges seen so far
   input wire [31:0]           cmd_seq_i,  // bumps once per command
   input wire [7:0]            cmd_i,
   input wire [31:0]           arg0_i,
   input wire [31:0]           arg1_i,
   input wire [31:0]           arg2_i,
   input wire [31:0]           arg3_i,
   input wire [8*24-1:0]       name_i,
   input wire [1:0]            xcvrsel_i,
   input wire                  termsel_i,
   input wire                  trig_i,
   input wire                  armed_i,
   input wire                  capturing_i,
   input wire                  cap_valid_i,
   input pw_pkg::cap_record_u  cap_record_i,
   output wire [31:0]          err_total_o,
   output wire [31:0]          ack_seq_o   // last command taken
);

   logic [17:0]     exp_q[$];   // records still to come
   logic [17:0]     exp_rec;
   logic            more_due;
   logic [8*24-1:0] name_q;
   logic [31:0]     seq_seen = 0;
   int              err_cnt = 0;
   int              test_err = 0;
   int              tests_run = 0;
   int              tests_failed = 0;
   int              rises = 0;
   int              hi_cycles = 0;
   logic [31:0]     rise_edge = 0;
   logic [31:0]     exp_rise = 0;
   logic [31:0]     exp_width = 0;
   logic            exp_trig = 1'b0;
   logic            trig_prev = 1'b0;

   assign err_total_o = err_cnt;
   assign ack_seq_o   = seq_seen;

   task automatic count_error();
      err_cnt  = err_cnt + 1;
      test_err = test_err + 1;
   endtask

   task automatic value_error(input [8*16-1:0] sig, input [31:0] exp, input [31:0] got);
      $display("[FAIL] %0s exp 0x%0h got 0x%0h", sig, exp, got);
      count_error();
   endtask

   task automatic end_of_test();
      if (exp_trig) begin
         if (rises != 1) begin
            $display("expected one trigger pulse but saw %0d", rises);
            count_error();
         end else begin
            if (rise_edge != exp_rise) value_error("trig_o rise edge", exp_rise, rise_edge);
            if (hi_cycles != exp_width) value_error("trig_o width", exp_width, hi_cycles);
         end
      end else if (rises != 0) begin
         $display("trigger fired where none was expected");
         count_error();
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected records never appeared", exp_q.size());
         count_error();
      end
      tests_run = tests_run + 1;
      if (test_err == 0) begin
         $display("test %0s: ok", name_q);
      end else begin
         $display("test %0s: failed with %0d errors", name_q, test_err);
         tests_failed = tests_failed + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // trace commands or the negedge output watch
   ////////////////////////////////////////////////////////////

   always @(negedge clk_i or cmd_seq_i) begin
      if (cmd_seq_i != seq_seen) begin
         seq_seen = cmd_seq_i;
         case (cmd_i)
            "T": begin
               name_q    = name_i;
               test_err  = 0;
               rises     = 0;
               hi_cycles = 0;
               exp_trig  = 1'b0;
               exp_q.delete();
            end
            "G": begin
               exp_trig  = (arg1_i != 0);
               exp_rise  = arg0_i;
               exp_width = arg1_i;
            end
            "C": exp_q.push_back(arg0_i[17:0]);
            "L": begin
               if (xcvrsel_i !== arg0_i[1:0]) value_error("xcvrsel_o", arg0_i, xcvrsel_i);
               if (termsel_i !== arg1_i[0]) value_error("termsel_o", arg1_i, termsel_i);
               if (capturing_i !== arg2_i[0]) value_error("capturing_o", arg2_i, capturing_i);
               if (armed_i !== arg3_i[0]) value_error("armed_o", arg3_i, armed_i);
            end
            "E": end_of_test();
            "Z": $display("tests %0d, passed %0d, failed %0d, errors %0d",
                          tests_run, tests_run - tests_failed, tests_failed, err_cnt);
            default: begin
               $display("unknown trace command 0x%0h", cmd_i);
               count_error();
            end
         endcase
      end else if (arst_n_i) begin
         if (trig_i && !trig_prev) begin
            rises     = rises + 1;
            rise_edge = cyc_i;   // edge that raised trig_o
         end
         if (trig_i) hi_cycles = hi_cycles + 1;
         trig_prev = trig_i;
         if (cap_valid_i) begin
            if (exp_q.size() == 0) begin
               $display("record 0x%05h arrived with none expected", cap_record_i);
               count_error();
            end else begin
               exp_rec = exp_q.pop_front();
               if (cap_record_i !== exp_rec) value_error("cap_record_o", exp_rec, cap_record_i);
               // capture stays open until its last record goes out
               more_due = (exp_q.size() != 0);
               if (capturing_i !== more_due) value_error("capturing_o", more_due, capturing_i);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`default_nettype none

module tb_top;

   logic                fe_clk_i = 1'b0;
   logic                arst_n_i = 1'b0;
   logic                reg_write_i = 1'b0;
   logic [7:0]          reg_addr_i = 8'h00;
   logic [7:0]          reg_data_i = 8'h00;
   logic [7:0]          fe_data_i = 8'h00;
   logic                fe_rxvalid_i = 1'b0;
   logic                fe_rxactive_i = 1'b0;
   logic                fe_rxerror_i = 1'b0;
   logic [1:0]          fe_linestate_i = 2'b00;
   wire  [1:0]          xcvrsel_o;
   wire                 termsel_o;
   wire                 trig_o;
   wire                 armed_o;
   wire                 capturing_o;
   wire                 cap_valid_o;
   pw_pkg::cap_record_u cap_record_o;

   logic [31:0]     cyc = 0;
   logic [31:0]     cyc_limit = 32'hffff_ffff;
   logic [31:0]     chk_seq = 0;
   logic [7:0]      chk_cmd = 8'h00;
   logic [31:0]     chk_a0 = 0;
   logic [31:0]     chk_a1 = 0;
   logic [31:0]     chk_a2 = 0;
   logic [31:0]     chk_a3 = 0;
   logic [8*24-1:0] chk_name = '0;
   wire  [31:0]     err_total;
   wire  [31:0]     chk_ack;
   logic            ended = 1'b0;
   logic            timed_out = 1'b0;

   // parsed trace
   logic [7:0]      cmd_a [0:255];
   logic [31:0]     a0_a [0:255];
   logic [31:0]     a1_a [0:255];
   logic [31:0]     a2_a [0:255];
   logic [31:0]     a3_a [0:255];
   logic [8*24-1:0] name_a [0:255];

   always #20 fe_clk_i = ~fe_clk_i;

   pw_top dut_i (.*);

   tb_checker u_checker (
      .clk_i (fe_clk_i), .arst_n_i (arst_n_i), .cyc_i (cyc),
      .cmd_seq_i (chk_seq), .cmd_i (chk_cmd),
      .arg0_i (chk_a0), .arg1_i (chk_a1), .arg2_i (chk_a2), .arg3_i (chk_a3),
      .name_i (chk_name), .xcvrsel_i (xcvrsel_o), .termsel_i (termsel_o),
      .trig_i (trig_o), .armed_i (armed_o), .capturing_i (capturing_o),
      .cap_valid_i (cap_valid_o), .cap_record_i (cap_record_o),
      .err_total_o (err_total),
      .ack_seq_o (chk_ack)
   );

   always @(posedge fe_clk_i) begin
      cyc <= cyc + 1;
      if (cyc >= cyc_limit) begin
         $display("timeout after %0d cycles, trace did not finish", cyc);
         $display("Test failed");
         timed_out = 1'b1;
         $finish;
      end
   end

   // one clock, then inputs go back to idle
   task automatic step();
      @(posedge fe_clk_i);
      #1;
      fe_rxvalid_i = 1'b0;
      reg_write_i  = 1'b0;
   endtask

   task automatic send(input [7:0] c, input [31:0] v0, input [31:0] v1,
                       input [31:0] v2, input [31:0] v3, input [8*24-1:0] nm);
      chk_cmd  = c;
      chk_a0   = v0;
      chk_a1   = v1;
      chk_a2   = v2;
      chk_a3   = v3;
      chk_name = nm;
      chk_seq  = chk_seq + 1;
      wait (chk_ack == chk_seq);  // checker has taken the command
   endtask

   initial begin
      int          fd;
      int          r;
      int          n;
      int          k;
      int          seed;
      int          gap;
      logic [31:0] total;
      logic [31:0] last_edge;
      logic [7:0]  c;
      logic [31:0] v0, v1, v2, v3;
      logic [8*24-1:0] nm;
      string       line;

      seed      = 32'hc2861c7b;
      n         = 0;
      total     = 0;
      last_edge = 0;
      fd = $fopen("pw_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open pw_trace.txt");
         $display("Test failed");
         ended = 1'b1;
         $finish;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            c = 8'h00;
            v0 = 0;
            v1 = 0;
            v2 = 0;
            v3 = 0;
            nm = '0;
            if (r > 0) r = $sscanf(line, "%c %h %h %h %h", c, v0, v1, v2, v3);
            if (c == "T") r = $sscanf(line, "%c %s", c, nm);
            if (c == "T" || c == "W" || c == "A" || c == "B" || c == "I" || c == "R" ||
                c == "G" || c == "C" || c == "L" || c == "E") begin
               cmd_a[n]  = c;
               a0_a[n]   = v0;
               a1_a[n]   = v1;
               a2_a[n]   = v2;
               a3_a[n]   = v3;
               name_a[n] = nm;
               if (c == "W" || c == "A" || c == "B") total = total + 1;
               if (c == "I" || c == "R") total = total + v0;
               n = n + 1;
            end
         end
         $fclose(fd);
         cyc_limit = total + 2 + 200;

         repeat (2) @(posedge fe_clk_i);
         #1;
         arst_n_i = 1'b1;

         for (k = 0; k < n; k++) begin
            c = cmd_a[k];
            case (c)
               "W": begin
                  reg_addr_i  = a0_a[k][7:0];
                  reg_data_i  = a1_a[k][7:0];
                  reg_write_i = 1'b1;
                  step();
               end
               "A": begin
                  fe_rxactive_i = a0_a[k][0];
                  step();
               end
               "B": begin
                  fe_data_i    = a0_a[k][7:0];
                  fe_rxvalid_i = 1'b1;
                  last_edge    = cyc + 1;   // sampled at the next edge
                  step();
               end
               "I": repeat (a0_a[k]) step();
               "R": begin
                  gap = $unsigned($random(seed)) % (a0_a[k] + 1);
                  repeat (gap) step();
               end
               "G": send(c, last_edge + a0_a[k], a1_a[k], 0, 0, name_a[k]);
               default: send(c, a0_a[k], a1_a[k], a2_a[k], a3_a[k], name_a[k]);
            endcase
         end

         send("Z", 0, 0, 0, 0, '0);
         if (err_total == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         ended = 1'b1;
         $finish;
      end
   end

   final begin
      if (!ended && !timed_out) $display("Test failed");  // stopped early
   end

endmodule

`default_nettype wire

// ==== pw_trace.txt ====
# T name | W addr data | A rxactive | B byte | I n idle | R n random idle 0..n
# G offset width (from last byte edge) | C record | L xcvrsel termsel capturing armed | E
T speed_decode
L 1 1 0 0
W 15 01
L 2 1 0 0
W 15 02
L 0 0 0 0
W 15 03
L 1 1 0 0
E
T no_match_unmasked
W 00 a5
W 01 5a
W 02 c3
W 08 ff
W 09 f0
W 0a ff
W 10 03
W 11 03
W 13 04
W 14 03
W 16 01
A 1
B a5
R 3
B 5a
R 3
B c2
G 0 0
B 11
A 0
I 10
L 1 1 0 1
E
T trigger_masked_match
A 1
B a5
B 5f
B c3
G 5 4
C 00177
C 00188
C 10300
B 77
B 88
I 2
A 0
I 12
L 1 1 0 0
E
T no_retrigger_unarmed
A 1
B a5
R 3
B 5a
B c3
G 0 0
A 0
I 10
L 1 1 0 0
E
T rearm_triggers
W 16 01
I 2
A 1
B a5
B 5a
B c3
G 5 4
C 00142
C 10100
C 10508
B 42
A 0
I 4
A 1
A 0
I 12
L 1 1 0 0
E

// ==== build.f ====
pw_pkg.sv
pw_regs.sv
fe_rx_front.sv
pattern_match.sv
trigger_gen.sv
capture_out.sv
pw_top.sv
pw_sva.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_top -o sim_pw
./obj_dir/sim_pw 2>&1 | tee sim.log
if grep -q "Test completed successfully" sim.log; then
   exit 0
else
   exit 1
fi
